//--- logic/trng_ctrl_pkg.sv
package trng_ctrl_pkg;

    localparam int FRAME_W    = 25;                                // SPI frame and state word
    localparam int ADDR_W     = 4;                                 // Register address
    localparam int TEMP_W     = 14;                                // Temp counters and thresholds
    localparam int CAL_STEP_W = 9;                                 // Percent per LSB
    localparam int ENT_CAL_W  = 16;                                // Upper byte N, lower byte P

    localparam logic [FRAME_W-1:0] DEFAULT_STATE = '0;             // All taps off
    localparam logic [FRAME_W-1:0] HALT_STATE    = 25'h0DEDBEF;    // Input pin left unrouted
    localparam logic [FRAME_W-1:0] INVALID_READ  = HALT_STATE;     // Unknown address reply

    // Frame fields
    localparam int OP_BIT  = 24;                                   // 1 register op, 0 debug state
    localparam int RD_BIT  = 23;                                   // 1 read
    localparam int ADDR_HI = 22;
    localparam int ADDR_LO = 19;

    // State word fields, 8-bit pin selects are module over cell
    localparam int PIN2_SEL_HI = 23;
    localparam int PIN1_SEL_HI = 15;
    localparam int IN_SEL_HI   = 7;                                // 3-bit module select

    // Register map
    localparam logic [ADDR_W-1:0] REG_DEFAULT  = 4'd0;             // Read-only constant
    localparam logic [ADDR_W-1:0] REG_HALT     = 4'd1;             // Read-only constant
    localparam logic [ADDR_W-1:0] REG_DEBUG    = 4'd2;             // Written by state frames
    localparam logic [ADDR_W-1:0] REG_CAL_STEP = 4'd3;
    localparam logic [ADDR_W-1:0] REG_ENT_CAL  = 4'd4;
    localparam logic [ADDR_W-1:0] REG_THRESH0  = 4'd5;             // Thresholds 5 to 8
    localparam logic [ADDR_W-1:0] REG_THRESH1  = 4'd6;
    localparam logic [ADDR_W-1:0] REG_THRESH2  = 4'd7;
    localparam logic [ADDR_W-1:0] REG_THRESH3  = 4'd8;
    localparam logic [ADDR_W-1:0] REG_TCNT0    = 4'd9;             // Live counters 9 to 12
    localparam logic [ADDR_W-1:0] REG_TCNT1    = 4'd10;
    localparam logic [ADDR_W-1:0] REG_TCNT2    = 4'd11;
    localparam logic [ADDR_W-1:0] REG_TCNT3    = 4'd12;

endpackage

//--- logic/spi_frame_slave.sv
`timescale 1ns/1ps

module spi_frame_slave (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               mosi,
    input  logic                               ss_n,
    input  logic                               reply_load,   // Load reply in frame_valid cycle
    input  logic [trng_ctrl_pkg::FRAME_W-1:0]  reply_data,
    output logic                               miso,
    output logic [trng_ctrl_pkg::FRAME_W-1:0]  frame_data,   // Held until next frame
    output logic                               frame_valid   // One cycle per frame
);

    logic [4:0]                          bit_cnt;            // Bits taken so far
    logic [trng_ctrl_pkg::FRAME_W-2:0]   rx_shift;           // Last bit goes straight out
    logic [trng_ctrl_pkg::FRAME_W-1:0]   tx_shift;
    logic                                last_bit;

    assign last_bit = !ss_n && (bit_cnt == 5'(trng_ctrl_pkg::FRAME_W - 1));
    assign miso     = tx_shift[trng_ctrl_pkg::FRAME_W-1];   // MSB first

    // Bit count and strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt     <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= last_bit;
            if (ss_n || last_bit) begin
                bit_cnt <= '0;                               // Deselect restarts the frame
            end else begin
                bit_cnt <= bit_cnt + 5'd1;
            end
        end
    end

    // Receive path
    always_ff @(posedge clk) begin
        if (!ss_n) begin
            rx_shift <= {rx_shift[trng_ctrl_pkg::FRAME_W-3:0], mosi};
        end
        if (last_bit) begin
            frame_data <= {rx_shift, mosi};                  // Complete word incl. final bit
        end
    end

    // Transmit path, reply goes out during the following frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_shift <= '0;
        end else if (reply_load) begin
            tx_shift <= reply_data;
        end else if (!ss_n) begin
            tx_shift <= {tx_shift[trng_ctrl_pkg::FRAME_W-2:0], 1'b0};   // Zeros follow
        end
    end

endmodule

//--- logic/ctrl_reg_file.sv
`timescale 1ns/1ps

module ctrl_reg_file (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  debug,
    input  logic [trng_ctrl_pkg::FRAME_W-1:0]     frame_data,
    input  logic                                  frame_valid,
    input  logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_counter_0,
    input  logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_counter_1,
    input  logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_counter_2,
    input  logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_counter_3,
    output logic                                  reply_load,
    output logic [trng_ctrl_pkg::FRAME_W-1:0]     reply_data,
    output logic [trng_ctrl_pkg::CAL_STEP_W-1:0]  calibration_step,
    output logic [trng_ctrl_pkg::ENT_CAL_W-1:0]   entropy_calibration,
    output logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_threshold_0,
    output logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_threshold_1,
    output logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_threshold_2,
    output logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_threshold_3,
    output logic [trng_ctrl_pkg::FRAME_W-1:0]     debug_state
);

    localparam int CAL_PAD  = trng_ctrl_pkg::FRAME_W - trng_ctrl_pkg::CAL_STEP_W;
    localparam int ENT_PAD  = trng_ctrl_pkg::FRAME_W - trng_ctrl_pkg::ENT_CAL_W;
    localparam int TEMP_PAD = trng_ctrl_pkg::FRAME_W - trng_ctrl_pkg::TEMP_W;

    logic                                 frame_ok;          // Accepted frame this cycle
    logic                                 reg_op;
    logic                                 rd_op;
    logic [trng_ctrl_pkg::ADDR_W-1:0]     addr;

    assign frame_ok   = frame_valid && debug;                // Frames dropped outside debug
    assign reg_op     = frame_data[trng_ctrl_pkg::OP_BIT];
    assign rd_op      = frame_data[trng_ctrl_pkg::RD_BIT];
    assign addr       = frame_data[trng_ctrl_pkg::ADDR_HI:trng_ctrl_pkg::ADDR_LO];
    assign reply_load = frame_ok && reg_op && rd_op;

    // Read mux, zero-extended
    always_comb begin
        case (addr)
            trng_ctrl_pkg::REG_DEFAULT:  reply_data = trng_ctrl_pkg::DEFAULT_STATE;
            trng_ctrl_pkg::REG_HALT:     reply_data = trng_ctrl_pkg::HALT_STATE;
            trng_ctrl_pkg::REG_DEBUG:    reply_data = debug_state;   // Stored word, not curr_state
            trng_ctrl_pkg::REG_CAL_STEP: reply_data = {{CAL_PAD{1'b0}}, calibration_step};
            trng_ctrl_pkg::REG_ENT_CAL:  reply_data = {{ENT_PAD{1'b0}}, entropy_calibration};
            trng_ctrl_pkg::REG_THRESH0:  reply_data = {{TEMP_PAD{1'b0}}, temp_threshold_0};
            trng_ctrl_pkg::REG_THRESH1:  reply_data = {{TEMP_PAD{1'b0}}, temp_threshold_1};
            trng_ctrl_pkg::REG_THRESH2:  reply_data = {{TEMP_PAD{1'b0}}, temp_threshold_2};
            trng_ctrl_pkg::REG_THRESH3:  reply_data = {{TEMP_PAD{1'b0}}, temp_threshold_3};
            trng_ctrl_pkg::REG_TCNT0:    reply_data = {{TEMP_PAD{1'b0}}, temp_counter_0};
            trng_ctrl_pkg::REG_TCNT1:    reply_data = {{TEMP_PAD{1'b0}}, temp_counter_1};
            trng_ctrl_pkg::REG_TCNT2:    reply_data = {{TEMP_PAD{1'b0}}, temp_counter_2};
            trng_ctrl_pkg::REG_TCNT3:    reply_data = {{TEMP_PAD{1'b0}}, temp_counter_3};
            default:                     reply_data = trng_ctrl_pkg::INVALID_READ;
        endcase
    end

    // Writes land on the edge closing the strobe cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            calibration_step    <= '0;
            entropy_calibration <= '0;
            temp_threshold_0    <= '0;
            temp_threshold_1    <= '0;
            temp_threshold_2    <= '0;
            temp_threshold_3    <= '0;
            debug_state         <= trng_ctrl_pkg::DEFAULT_STATE;
        end else if (frame_ok && !reg_op) begin
            debug_state <= frame_data;                       // Whole frame is the new state
        end else if (frame_ok && !rd_op) begin
            case (addr)
                trng_ctrl_pkg::REG_CAL_STEP:
                    calibration_step <= frame_data[trng_ctrl_pkg::CAL_STEP_W-1:0];
                trng_ctrl_pkg::REG_ENT_CAL:
                    entropy_calibration <= frame_data[trng_ctrl_pkg::ENT_CAL_W-1:0];
                trng_ctrl_pkg::REG_THRESH0: temp_threshold_0 <= frame_data[trng_ctrl_pkg::TEMP_W-1:0];
                trng_ctrl_pkg::REG_THRESH1: temp_threshold_1 <= frame_data[trng_ctrl_pkg::TEMP_W-1:0];
                trng_ctrl_pkg::REG_THRESH2: temp_threshold_2 <= frame_data[trng_ctrl_pkg::TEMP_W-1:0];
                trng_ctrl_pkg::REG_THRESH3: temp_threshold_3 <= frame_data[trng_ctrl_pkg::TEMP_W-1:0];
                default: ;                                   // Read-only or unmapped
            endcase
        end
    end

endmodule

//--- logic/debug_pin_mux.sv
`timescale 1ns/1ps

module debug_pin_mux (
    input  logic       debug,
    input  logic [7:0] sel,                      // Module over cell select
    input  logic       clk,                      // Routed as data to the pad
    input  logic       conditioner_mux_output,
    input  logic       DRBG_mux_output,
    input  logic       temp_sense_0_good,
    input  logic       temp_sense_1_good,
    input  logic       temp_sense_2_good,
    input  logic       temp_sense_3_good,
    input  logic       latch_entropy_mux_out,
    input  logic       jitter_entropy_mux_out,
    input  logic       latch_oht_mux_out,
    input  logic       jitter_oht_mux_out,
    input  logic       latch_sram_mux_out,
    input  logic       jitter_sram_mux_out,
    output logic       pin
);

    logic fixed_src;                             // Module 0 source

    always_comb begin
        case (sel[4:0])
            5'd0:       fixed_src = 1'b1;
            5'd1:       fixed_src = clk;
            5'd2:       fixed_src = conditioner_mux_output;
            5'd3, 5'd4: fixed_src = DRBG_mux_output;    // Two cells, same tap
            5'd5:       fixed_src = temp_sense_0_good;
            5'd6:       fixed_src = temp_sense_1_good;
            5'd7:       fixed_src = temp_sense_2_good;
            5'd8:       fixed_src = temp_sense_3_good;
            default:    fixed_src = 1'b0;
        endcase
    end

    always_comb begin
        pin = 1'b0;                              // Quiet outside debug
        if (debug) begin
            case (sel[7:5])
                3'd0:    pin = fixed_src;
                3'd1:    pin = latch_entropy_mux_out;
                3'd2:    pin = jitter_entropy_mux_out;
                3'd3:    pin = latch_oht_mux_out;
                3'd4:    pin = jitter_oht_mux_out;
                3'd5:    pin = latch_sram_mux_out;
                3'd6:    pin = jitter_sram_mux_out;
                default: pin = 1'b0;
            endcase
        end
    end

endmodule

//--- logic/control.sv
`timescale 1ns/1ps

module control (
    input  logic                                  ic_clk,        // Board oscillator
    input  logic                                  debug_clk,     // Clock from the debug host
    input  logic                                  rst_n,
    input  logic                                  mosi,
    input  logic                                  ss_n,
    input  logic                                  debug,
    input  logic                                  input_pin_1,
    input  logic                                  latch_entropy_mux_out,
    input  logic                                  jitter_entropy_mux_out,
    input  logic                                  latch_oht_mux_out,
    input  logic                                  jitter_oht_mux_out,
    input  logic                                  latch_sram_mux_out,
    input  logic                                  jitter_sram_mux_out,
    input  logic                                  conditioner_mux_output,
    input  logic                                  DRBG_mux_output,
    input  logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_counter_0,
    input  logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_counter_1,
    input  logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_counter_2,
    input  logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_counter_3,
    input  logic                                  temp_sense_0_good,
    input  logic                                  temp_sense_1_good,
    input  logic                                  temp_sense_2_good,
    input  logic                                  temp_sense_3_good,
    output logic                                  clk,
    output logic                                  miso,
    output logic                                  output_pin_1,
    output logic                                  output_pin_2,
    output logic                                  latch_oht_mux_in,
    output logic                                  jitter_oht_mux_in,
    output logic                                  latch_sram_mux_in,
    output logic                                  jitter_sram_mux_in,
    output logic                                  conditioner_mux_input,  // Routing not built
    output logic                                  DRBG_mux_input,         // Routing not built
    output logic [trng_ctrl_pkg::CAL_STEP_W-1:0]  calibration_step,
    output logic [trng_ctrl_pkg::ENT_CAL_W-1:0]   entropy_calibration,
    output logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_threshold_0,
    output logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_threshold_1,
    output logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_threshold_2,
    output logic [trng_ctrl_pkg::TEMP_W-1:0]      temp_threshold_3,
    output logic [trng_ctrl_pkg::FRAME_W-1:0]     curr_state,
    output logic                                  spi_data_ready
);

    logic [trng_ctrl_pkg::FRAME_W-1:0] frame_data;
    logic                              frame_valid;
    logic                              reply_load;
    logic [trng_ctrl_pkg::FRAME_W-1:0] reply_data;
    logic [trng_ctrl_pkg::FRAME_W-1:0] debug_state;
    logic [trng_ctrl_pkg::FRAME_W-1:0] next_state;
    logic                              temps_good;
    logic [2:0]                        in_sel;             // Input pin destination

    assign clk            = debug ? debug_clk : ic_clk;   // Host takes over in debug
    assign spi_data_ready = frame_valid;
    assign temps_good     = temp_sense_0_good && temp_sense_1_good
                         && temp_sense_2_good && temp_sense_3_good;

    // Halt wins over everything
    always_comb begin
        if (!temps_good) begin
            next_state = trng_ctrl_pkg::HALT_STATE;
        end else if (debug) begin
            next_state = debug_state;
        end else begin
            next_state = trng_ctrl_pkg::DEFAULT_STATE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_state <= trng_ctrl_pkg::DEFAULT_STATE;
        end else begin
            curr_state <= next_state;
        end
    end

    // Input pin fan-out, one macro at a time
    assign in_sel             = curr_state[trng_ctrl_pkg::IN_SEL_HI -: 3];
    assign latch_oht_mux_in   = debug && (in_sel == 3'd1) && input_pin_1;
    assign jitter_oht_mux_in  = debug && (in_sel == 3'd2) && input_pin_1;
    assign latch_sram_mux_in  = debug && (in_sel == 3'd3) && input_pin_1;
    assign jitter_sram_mux_in = debug && (in_sel == 3'd4) && input_pin_1;
    assign conditioner_mux_input = 1'b0;
    assign DRBG_mux_input        = 1'b0;

    spi_frame_slave u_spi (
        .clk         (clk),
        .rst_n       (rst_n),
        .mosi        (mosi),
        .ss_n        (ss_n),
        .reply_load  (reply_load),
        .reply_data  (reply_data),
        .miso        (miso),
        .frame_data  (frame_data),
        .frame_valid (frame_valid)
    );

    ctrl_reg_file u_regs (
        .clk                 (clk),
        .rst_n               (rst_n),
        .debug               (debug),
        .frame_data          (frame_data),
        .frame_valid         (frame_valid),
        .temp_counter_0      (temp_counter_0),
        .temp_counter_1      (temp_counter_1),
        .temp_counter_2      (temp_counter_2),
        .temp_counter_3      (temp_counter_3),
        .reply_load          (reply_load),
        .reply_data          (reply_data),
        .calibration_step    (calibration_step),
        .entropy_calibration (entropy_calibration),
        .temp_threshold_0    (temp_threshold_0),
        .temp_threshold_1    (temp_threshold_1),
        .temp_threshold_2    (temp_threshold_2),
        .temp_threshold_3    (temp_threshold_3),
        .debug_state         (debug_state)
    );

    debug_pin_mux u_pin2 (
        .debug                  (debug),
        .sel                    (curr_state[trng_ctrl_pkg::PIN2_SEL_HI -: 8]),
        .clk                    (clk),
        .conditioner_mux_output (conditioner_mux_output),
        .DRBG_mux_output        (DRBG_mux_output),
        .temp_sense_0_good      (temp_sense_0_good),
        .temp_sense_1_good      (temp_sense_1_good),
        .temp_sense_2_good      (temp_sense_2_good),
        .temp_sense_3_good      (temp_sense_3_good),
        .latch_entropy_mux_out  (latch_entropy_mux_out),
        .jitter_entropy_mux_out (jitter_entropy_mux_out),
        .latch_oht_mux_out      (latch_oht_mux_out),
        .jitter_oht_mux_out     (jitter_oht_mux_out),
        .latch_sram_mux_out     (latch_sram_mux_out),
        .jitter_sram_mux_out    (jitter_sram_mux_out),
        .pin                    (output_pin_2)
    );

    debug_pin_mux u_pin1 (
        .debug                  (debug),
        .sel                    (curr_state[trng_ctrl_pkg::PIN1_SEL_HI -: 8]),
        .clk                    (clk),
        .conditioner_mux_output (conditioner_mux_output),
        .DRBG_mux_output        (DRBG_mux_output),
        .temp_sense_0_good      (temp_sense_0_good),
        .temp_sense_1_good      (temp_sense_1_good),
        .temp_sense_2_good      (temp_sense_2_good),
        .temp_sense_3_good      (temp_sense_3_good),
        .latch_entropy_mux_out  (latch_entropy_mux_out),
        .jitter_entropy_mux_out (jitter_entropy_mux_out),
        .latch_oht_mux_out      (latch_oht_mux_out),
        .jitter_oht_mux_out     (jitter_oht_mux_out),
        .latch_sram_mux_out     (latch_sram_mux_out),
        .jitter_sram_mux_out    (jitter_sram_mux_out),
        .pin                    (output_pin_1)
    );

endmodule

//--- bench/control_props.sv
`timescale 1ns/1ps

module control_props (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               debug,
    input logic                               spi_data_ready,
    input logic                               all_good,     // AND of the four sensors
    input logic [trng_ctrl_pkg::FRAME_W-1:0]  curr_state,
    input logic                               output_pin_1,
    input logic                               output_pin_2
);

    // One strobe per frame, never two in a row
    strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        spi_data_ready |=> !spi_data_ready)
        else $error("spi_data_ready high two cycles");

    halt_entry: assert property (@(posedge clk) disable iff (!rst_n)
        !all_good |=> curr_state == trng_ctrl_pkg::HALT_STATE)
        else $error("no halt after sensor failure");

    pins_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !debug |-> (!output_pin_1 && !output_pin_2))
        else $error("output pin active outside debug");

    // Default state one edge after debug drops, halt excluded
    default_outside_debug: assert property (@(posedge clk) disable iff (!rst_n)
        (!$past(debug) && $past(all_good)) |-> curr_state == trng_ctrl_pkg::DEFAULT_STATE)
        else $error("state not default after debug low");

endmodule

bind control control_props props (
    .clk            (clk),
    .rst_n          (rst_n),
    .debug          (debug),
    .spi_data_ready (spi_data_ready),
    .all_good       (temps_good),
    .curr_state     (curr_state),
    .output_pin_1   (output_pin_1),
    .output_pin_2   (output_pin_2)
);

//--- bench/control_tb.sv
`timescale 1ns/1ps

module control_tb;

    localparam int MAX_CYCLES = 5000;                        // Some 55 frames of 28 cycles plus margin

    logic        tb_clk;
    logic        rst_n, mosi, ss_n, debug, input_pin_1;
    logic        latch_entropy_mux_out, jitter_entropy_mux_out;
    logic        latch_oht_mux_out, jitter_oht_mux_out;
    logic        latch_sram_mux_out, jitter_sram_mux_out;
    logic        conditioner_mux_output, DRBG_mux_output;
    logic [13:0] temp_counter_0, temp_counter_1, temp_counter_2, temp_counter_3;
    logic        temp_sense_0_good, temp_sense_1_good, temp_sense_2_good, temp_sense_3_good;
    logic        clk, miso, output_pin_1, output_pin_2;
    logic        latch_oht_mux_in, jitter_oht_mux_in, latch_sram_mux_in, jitter_sram_mux_in;
    logic        conditioner_mux_input, DRBG_mux_input;
    logic [8:0]  calibration_step;
    logic [15:0] entropy_calibration;
    logic [13:0] temp_threshold_0, temp_threshold_1, temp_threshold_2, temp_threshold_3;
    logic [24:0] curr_state;
    logic        spi_data_ready;

    // Mirror of accepted writes
    logic [8:0]  m_cal;
    logic [15:0] m_ent;
    logic [13:0] m_thr [4];
    logic [24:0] m_debug;

    integer seed = 32'h1d14;
    int     errors, checks, test_errs, cycles;

    control dut (.ic_clk(tb_clk), .debug_clk(tb_clk), .*);

    initial begin
        tb_clk = 1'b0;
        forever #50 tb_clk = ~tb_clk;                        // 100 ns period
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge tb_clk);
            cycles++;
            if (cycles >= MAX_CYCLES) begin
                $display("Timeout after %0d cycles, tests did not complete", cycles);
                $display("Finished with errors");
                $finish;
            end
        end
    end

    // Pin mux rule
    function automatic logic exp_pin(input logic dbg, input logic [7:0] sel, input logic ck);
        logic r;
        r = 1'b0;
        if (dbg) begin
            case (sel[7:5])
                3'd0: begin
                    case (sel[4:0])
                        5'd0:       r = 1'b1;
                        5'd1:       r = ck;
                        5'd2:       r = conditioner_mux_output;
                        5'd3, 5'd4: r = DRBG_mux_output;
                        5'd5:       r = temp_sense_0_good;
                        5'd6:       r = temp_sense_1_good;
                        5'd7:       r = temp_sense_2_good;
                        5'd8:       r = temp_sense_3_good;
                        default:    r = 1'b0;
                    endcase
                end
                3'd1: r = latch_entropy_mux_out;
                3'd2: r = jitter_entropy_mux_out;
                3'd3: r = latch_oht_mux_out;
                3'd4: r = jitter_oht_mux_out;
                3'd5: r = latch_sram_mux_out;
                3'd6: r = jitter_sram_mux_out;
                default: r = 1'b0;
            endcase
        end
        return r;
    endfunction

    // Register read rule, zero-extended
    function automatic logic [24:0] exp_reply(input logic [3:0] addr);
        case (addr)
            4'd0:    return 25'h0;
            4'd1:    return 25'h0DEDBEF;
            4'd2:    return m_debug;
            4'd3:    return {16'b0, m_cal};
            4'd4:    return {9'b0, m_ent};
            4'd5:    return {11'b0, m_thr[0]};
            4'd6:    return {11'b0, m_thr[1]};
            4'd7:    return {11'b0, m_thr[2]};
            4'd8:    return {11'b0, m_thr[3]};
            4'd9:    return {11'b0, temp_counter_0};
            4'd10:   return {11'b0, temp_counter_1};
            4'd11:   return {11'b0, temp_counter_2};
            4'd12:   return {11'b0, temp_counter_3};
            default: return 25'h0DEDBEF;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [24:0] exp, input logic [24:0] act);
        checks++;
        if (exp !== act) begin
            $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s done, %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    // 25 bits MSB first, miso captured mid-cycle
    task automatic send_frame(input logic [24:0] f, output logic [24:0] rx);
        int waited;
        for (int i = 24; i >= 0; i--) begin
            @(posedge tb_clk);
            ss_n <= 1'b0;
            mosi <= f[i];
            @(negedge tb_clk);
            rx[i] = miso;
        end
        @(posedge tb_clk);
        ss_n <= 1'b1;
        mosi <= 1'b0;
        waited = 0;
        @(negedge tb_clk);
        while (!spi_data_ready && waited < 4) begin
            @(negedge tb_clk);
            waited++;
        end
        if (!spi_data_ready) begin
            $display("Frame strobe never came at %0t", $time);
            errors++;
            test_errs++;
        end
        @(posedge tb_clk);                                   // Write edge
        @(posedge tb_clk);                                   // State edge
        @(negedge tb_clk);
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [18:0] data);
        logic [24:0] rx;
        send_frame({1'b1, 1'b0, addr, data}, rx);
        if (debug) begin
            case (addr)
                4'd3:    m_cal = data[8:0];
                4'd4:    m_ent = data[15:0];
                4'd5, 4'd6, 4'd7, 4'd8: m_thr[addr - 4'd5] = data[13:0];
                default: ;
            endcase
        end
    endtask

    task automatic write_state(input logic [23:0] word);
        logic [24:0] rx;
        send_frame({1'b0, word}, rx);
        if (debug) m_debug = {1'b0, word};
    endtask

    // Reply shows up in the frame after the read
    task automatic read_reg(input logic [3:0] addr, output logic [24:0] data);
        logic [24:0] rx;
        send_frame({1'b1, 1'b1, addr, 19'b0}, rx);
        send_frame({1'b1, 1'b1, 4'd0, 19'b0}, data);
    endtask

    task automatic randomize_inputs;
        logic [31:0] r;
        logic [31:0] c;
        @(posedge tb_clk);
        r = $random(seed);
        latch_entropy_mux_out  <= r[0];
        jitter_entropy_mux_out <= r[1];
        latch_oht_mux_out      <= r[2];
        jitter_oht_mux_out     <= r[3];
        latch_sram_mux_out     <= r[4];
        jitter_sram_mux_out    <= r[5];
        conditioner_mux_output <= r[6];
        DRBG_mux_output        <= r[7];
        input_pin_1            <= r[8];
        c = $random(seed);
        temp_counter_0 <= c[13:0];
        temp_counter_1 <= c[27:14];
        c = $random(seed);
        temp_counter_2 <= c[13:0];
        temp_counter_3 <= c[27:14];
        @(negedge tb_clk);
    endtask

    task automatic check_outputs(input logic ck);
        logic [2:0] in_sel;
        in_sel = m_debug[7:5];
        check_val("clk", 25'(ck), 25'(clk));
        check_val("curr_state", m_debug, curr_state);
        check_val("output_pin_2", 25'(exp_pin(debug, m_debug[23:16], ck)), 25'(output_pin_2));
        check_val("output_pin_1", 25'(exp_pin(debug, m_debug[15:8], ck)), 25'(output_pin_1));
        check_val("latch_oht_mux_in", 25'(in_sel == 3'd1 && input_pin_1), 25'(latch_oht_mux_in));
        check_val("jitter_oht_mux_in", 25'(in_sel == 3'd2 && input_pin_1), 25'(jitter_oht_mux_in));
        check_val("latch_sram_mux_in", 25'(in_sel == 3'd3 && input_pin_1), 25'(latch_sram_mux_in));
        check_val("jitter_sram_mux_in", 25'(in_sel == 3'd4 && input_pin_1),
                  25'(jitter_sram_mux_in));
        check_val("conditioner_mux_input", 25'h0, 25'(conditioner_mux_input));   // Held low
        check_val("DRBG_mux_input", 25'h0, 25'(DRBG_mux_input));
    endtask

    task automatic check_regs;
        check_val("calibration_step", 25'(m_cal), 25'(calibration_step));
        check_val("entropy_calibration", 25'(m_ent), 25'(entropy_calibration));
        check_val("temp_threshold_0", 25'(m_thr[0]), 25'(temp_threshold_0));
        check_val("temp_threshold_1", 25'(m_thr[1]), 25'(temp_threshold_1));
        check_val("temp_threshold_2", 25'(m_thr[2]), 25'(temp_threshold_2));
        check_val("temp_threshold_3", 25'(m_thr[3]), 25'(temp_threshold_3));
    endtask

    initial begin
        logic [24:0] data;
        logic [31:0] r;
        logic [23:0] saved;
        errors = 0;
        checks = 0;
        test_errs = 0;
        rst_n = 1'b0;
        mosi = 1'b0;
        ss_n = 1'b1;
        debug = 1'b0;                                        // Pins idle out of reset
        input_pin_1 = 1'b0;
        {latch_entropy_mux_out, jitter_entropy_mux_out} = 2'b00;
        {latch_oht_mux_out, jitter_oht_mux_out} = 2'b00;
        {latch_sram_mux_out, jitter_sram_mux_out} = 2'b00;
        {conditioner_mux_output, DRBG_mux_output} = 2'b00;
        {temp_counter_0, temp_counter_1, temp_counter_2, temp_counter_3} = '0;
        {temp_sense_0_good, temp_sense_1_good, temp_sense_2_good, temp_sense_3_good} = 4'hf;
        m_cal = '0;
        m_ent = '0;
        m_thr = '{default: '0};
        m_debug = '0;
        repeat (10) @(posedge tb_clk);
        rst_n <= 1'b1;
        @(negedge tb_clk);

        // 1. Reset values
        check_outputs(1'b0);
        check_val("spi_data_ready", 25'h0, 25'(spi_data_ready));
        check_regs();
        end_test("reset");

        // 2. Writable registers and read-back
        @(posedge tb_clk);
        debug <= 1'b1;
        for (int a = 3; a <= 8; a++) begin
            r = $random(seed);
            write_reg(4'(a), r[18:0]);
        end
        check_regs();
        for (int a = 0; a <= 8; a++) begin
            read_reg(4'(a), data);
            check_val($sformatf("reply addr %0d", a), exp_reply(4'(a)), data);
        end
        write_reg(4'd1, 19'h5a5a5);
        write_reg(4'd9, 19'h12345);
        check_regs();
        end_test("registers");

        // 3. Counters and unmapped addresses
        randomize_inputs();
        for (int a = 9; a <= 15; a++) begin
            read_reg(4'(a), data);
            check_val($sformatf("reply addr %0d", a), exp_reply(4'(a)), data);
        end
        end_test("counters");

        // 4. Debug states, constant and clock cells first
        write_state(24'h000120);                             // Pin2 const, pin1 clk
        check_outputs(1'b0);
        @(posedge tb_clk);
        #10;
        check_outputs(1'b1);
        @(negedge tb_clk);
        write_state(24'h0305a0);
        check_outputs(1'b0);
        for (int n = 0; n < 8; n++) begin
            randomize_inputs();
            r = $random(seed);
            write_state(r[23:0]);
            check_outputs(1'b0);
        end
        end_test("debug_state");

        // 5. Sensor failure forces halt
        saved = m_debug[23:0];
        @(posedge tb_clk);
        temp_sense_2_good <= 1'b0;
        @(posedge tb_clk);
        @(negedge tb_clk);
        check_val("curr_state", 25'h0DEDBEF, curr_state);
        read_reg(4'd2, data);
        check_val("reply addr 2", {1'b0, saved}, data);
        check_val("curr_state", 25'h0DEDBEF, curr_state);
        @(posedge tb_clk);
        temp_sense_2_good <= 1'b1;
        @(posedge tb_clk);
        @(negedge tb_clk);
        check_outputs(1'b0);
        end_test("halt");

        // 6. Frames dropped with debug low
        @(posedge tb_clk);
        debug <= 1'b0;
        write_state(24'h2a55c3);
        write_reg(4'd3, 19'h000ff);
        check_val("curr_state", 25'h0, curr_state);
        check_val("output_pin_1", 25'h0, 25'(output_pin_1));
        check_val("output_pin_2", 25'h0, 25'(output_pin_2));
        check_val("latch_oht_mux_in", 25'h0, 25'(latch_oht_mux_in));
        check_regs();
        @(posedge tb_clk);
        debug <= 1'b1;
        @(posedge tb_clk);
        @(negedge tb_clk);
        check_outputs(1'b0);
        end_test("debug_low");

        $display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- all.f
logic/trng_ctrl_pkg.sv
logic/spi_frame_slave.sv
logic/ctrl_reg_file.sv
logic/debug_pin_mux.sv
logic/control.sv
bench/control_props.sv
bench/control_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := control_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
PASS_MSG  := Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(SIM_LOG) 2>&1 || true
	cat $(SIM_LOG)
	grep -q "$(PASS_MSG)" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
